// ==== verilog/cpu_isa_pkg.sv ====
//////////////////////////////////////////////////
// Integer ISA encoding
// Word and register types, opcode and funct values
// and the bit positions of the instruction fields
//////////////////////////////////////////////////

package cpu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam reg_addr_t REG_ZERO = 5'd0;

    // Primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;  // R-type, operation in funct
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;

    // SPECIAL funct codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // Field positions inside the instruction word
    localparam int OPC_MSB   = 31;
    localparam int OPC_LSB   = 26;
    localparam int RS_MSB    = 25;
    localparam int RS_LSB    = 21;
    localparam int RT_MSB    = 20;
    localparam int RT_LSB    = 16;
    localparam int RD_MSB    = 15;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_MSB = 10;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_MSB = 5;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_MSB   = 15;
    localparam int IMM_LSB   = 0;

endpackage

// ==== verilog/cpu_ctrl_pkg.sv ====
//////////////////////////////////////////////////
// Internal control encoding
// ALU operation codes and operand B sources
//////////////////////////////////////////////////

package cpu_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,   // Signed compare
        ALU_SLTU = 4'd7,   // Unsigned compare
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // SRC_SHAMT also moves rt to operand B and shamt to operand A
    typedef enum logic [1:0] {
        SRC_REG      = 2'd0,
        SRC_SIGN_IMM = 2'd1,
        SRC_ZERO_IMM = 2'd2,
        SRC_SHAMT    = 2'd3
    } src_b_e;

endpackage

// ==== verilog/cpu_buses.sv ====
//////////////////////////////////////////////////
// Pipeline bundles
// Decode to execute operand bundle and the
// writeback bundle seen by the register file,
// the bypass unit and the debug trace
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface decode_bus_if import cpu_isa_pkg::*, cpu_ctrl_pkg::*; ();

    logic      valid;
    alu_op_e   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    reg_addr_t waddr;
    logic      wen;       // Only set for a real write to a nonzero register
    word_t     inst;

    modport producer (
        output valid, alu_op, operand_a, operand_b, waddr, wen, inst
    );

    modport consumer (
        input valid, alu_op, operand_a, operand_b, waddr, wen, inst
    );

endinterface

interface wb_bus_if import cpu_isa_pkg::*; ();

    logic      valid;
    logic      wen;
    reg_addr_t waddr;
    word_t     wdata;
    word_t     inst;      // Retired instruction word for the trace

    modport producer (output valid, wen, waddr, wdata, inst);
    modport sink     (input  valid, wen, waddr, wdata, inst);

endinterface

// ==== verilog/alu.sv ====
//////////////////////////////////////////////////
// ALU
// Wrapping add and subtract, bitwise logic,
// compares, shifts and LUI
//////////////////////////////////////////////////

`timescale 1ns/1ps

module alu
    import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] sa;

    assign sa = a[4:0];  // Shift amount comes in on a

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            ALU_SLL:  result = b << sa;
            ALU_SRL:  result = b >> sa;
            ALU_SRA:  result = $signed(b) >>> sa;
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
//////////////////////////////////////////////////
// Register file
// 31 writable registers, register zero reads zero,
// written from the writeback bundle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_file
    import cpu_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    wb_bus_if.sink    wb,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.wen && (wb.waddr != REG_ZERO)) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    assign rs_data = (rs_addr == REG_ZERO) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == REG_ZERO) ? '0 : regs[rt_addr];

    // Decode must never let a write to register zero reach this far
    a_no_zero_write: assert property (@(posedge clk) disable iff (reset)
        (wb.valid && wb.wen) |-> (wb.waddr != REG_ZERO));

endmodule

// ==== verilog/bypass_unit.sv ====
//////////////////////////////////////////////////
// Operand bypass
// Returns the newest value of each source register
// from execute, writeback or the register file
//////////////////////////////////////////////////

`timescale 1ns/1ps

module bypass_unit
    import cpu_isa_pkg::*;
(
    input  reg_addr_t      rs_addr,
    input  reg_addr_t      rt_addr,
    input  word_t          rs_data,
    input  word_t          rt_data,
    decode_bus_if.consumer exe,
    input  word_t          exe_result,
    wb_bus_if.sink         wb,
    output word_t          rs_value,
    output word_t          rt_value
);

    logic exe_hit_rs;
    logic exe_hit_rt;
    logic wb_hit_rs;
    logic wb_hit_rt;

    // wen is already clear for bubbles and register zero
    assign exe_hit_rs = exe.wen && (exe.waddr == rs_addr);
    assign exe_hit_rt = exe.wen && (exe.waddr == rt_addr);

    assign wb_hit_rs = wb.valid && wb.wen && (wb.waddr == rs_addr);
    assign wb_hit_rt = wb.valid && wb.wen && (wb.waddr == rt_addr);

    // Newest first
    assign rs_value = exe_hit_rs ? exe_result :
                      wb_hit_rs  ? wb.wdata   :
                                   rs_data;

    assign rt_value = exe_hit_rt ? exe_result :
                      wb_hit_rt  ? wb.wdata   :
                                   rt_data;

endmodule

// ==== verilog/decode_stage.sv ====
//////////////////////////////////////////////////
// Decode stage
// Latches each strobed instruction, decodes its
// fields, extends the immediate and builds the
// operand bundle handed to execute
//////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage
    import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           inst_valid,
    input  word_t          inst,
    output reg_addr_t      rs_addr,
    output reg_addr_t      rt_addr,
    input  word_t          rs_value,
    input  word_t          rt_value,
    decode_bus_if.producer dec
);

    logic      valid_q;
    word_t     inst_q;
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rd_addr;
    logic [4:0] shamt;
    logic [15:0] imm;
    word_t     sign_imm;
    word_t     zero_imm;
    alu_op_e   alu_op;
    src_b_e    src_b;
    logic      known;      // Encoding is supported
    logic      rd_dest;    // R-type writes rd, I-type writes rt
    reg_addr_t waddr;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= inst_valid;  // Low strobe leaves a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            inst_q <= inst;
        end
    end

    assign opcode  = inst_q[OPC_MSB:OPC_LSB];
    assign funct   = inst_q[FUNCT_MSB:FUNCT_LSB];
    assign rs_addr = inst_q[RS_MSB:RS_LSB];
    assign rt_addr = inst_q[RT_MSB:RT_LSB];
    assign rd_addr = inst_q[RD_MSB:RD_LSB];
    assign shamt   = inst_q[SHAMT_MSB:SHAMT_LSB];
    assign imm     = inst_q[IMM_MSB:IMM_LSB];

    assign sign_imm = {{16{imm[15]}}, imm};
    assign zero_imm = {16'h0000, imm};

    always_comb begin
        alu_op  = ALU_ADD;
        known   = 1'b1;
        rd_dest = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                rd_dest = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: known  = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_SLTIU: alu_op = ALU_SLTU;   // Immediate still sign extended
            OP_ANDI:  alu_op = ALU_AND;
            OP_ORI:   alu_op = ALU_OR;
            OP_XORI:  alu_op = ALU_XOR;
            OP_LUI:   alu_op = ALU_LUI;
            default:  known  = 1'b0;
        endcase
    end

    // Logic ops and LUI zero extend, arithmetic and compares sign extend
    always_comb begin
        if (opcode == OP_SPECIAL) begin
            src_b = (funct inside {FN_SLL, FN_SRL, FN_SRA}) ? SRC_SHAMT : SRC_REG;
        end else if (opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
            src_b = SRC_ZERO_IMM;
        end else begin
            src_b = SRC_SIGN_IMM;
        end
    end

    always_comb begin
        dec.operand_a = rs_value;
        case (src_b)
            SRC_SIGN_IMM: dec.operand_b = sign_imm;
            SRC_ZERO_IMM: dec.operand_b = zero_imm;
            SRC_SHAMT: begin
                dec.operand_a = {27'd0, shamt};  // Shift amount
                dec.operand_b = rt_value;        // Value to shift
            end
            default: dec.operand_b = rt_value;
        endcase
    end

    assign waddr = rd_dest ? rd_addr : rt_addr;

    assign dec.valid  = valid_q;
    assign dec.alu_op = alu_op;
    assign dec.waddr  = waddr;
    assign dec.wen    = valid_q && known && (waddr != REG_ZERO);
    assign dec.inst   = inst_q;

    // A valid instruction never picks up an unknown operand
    a_operands_known: assert property (@(posedge clk) disable iff (reset)
        dec.valid |-> !$isunknown({rs_value, rt_value}));

endmodule

// ==== verilog/execute_stage.sv ====
//////////////////////////////////////////////////
// Execute stage
// Registers the decode bundle, runs the ALU and
// loads the writeback bundle behind it
//////////////////////////////////////////////////

`timescale 1ns/1ps

module execute_stage
    import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    decode_bus_if.consumer dec,
    decode_bus_if.producer exe_bus,
    output word_t          exe_result,
    wb_bus_if.producer     wb
);

    logic      exe_valid;
    logic      exe_wen;
    alu_op_e   exe_op;
    word_t     exe_a;
    word_t     exe_b;
    reg_addr_t exe_waddr;
    word_t     exe_inst;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
            exe_wen   <= 1'b0;
            wb.valid  <= 1'b0;
            wb.wen    <= 1'b0;
        end else begin
            exe_valid <= dec.valid;
            exe_wen   <= dec.wen;
            wb.valid  <= exe_valid;
            wb.wen    <= exe_wen;
        end
    end

    always_ff @(posedge clk) begin
        exe_op    <= dec.alu_op;
        exe_a     <= dec.operand_a;
        exe_b     <= dec.operand_b;
        exe_waddr <= dec.waddr;
        exe_inst  <= dec.inst;
        wb.waddr  <= exe_waddr;
        wb.wdata  <= exe_result;
        wb.inst   <= exe_inst;
    end

    alu u_alu (
        .op     (exe_op),
        .a      (exe_a),
        .b      (exe_b),
        .result (exe_result)
    );

    // Registered copy for the bypass unit
    assign exe_bus.valid     = exe_valid;
    assign exe_bus.alu_op    = exe_op;
    assign exe_bus.operand_a = exe_a;
    assign exe_bus.operand_b = exe_b;
    assign exe_bus.waddr     = exe_waddr;
    assign exe_bus.wen       = exe_wen;
    assign exe_bus.inst      = exe_inst;

    // A write enable only ever travels with a valid instruction
    a_wb_wen_valid: assert property (@(posedge clk) disable iff (reset)
        wb.wen |-> wb.valid);

endmodule

// ==== verilog/cpu_top.sv ====
//////////////////////////////////////////////////
// Integer pipeline top
// Three stages, decode, execute and writeback,
// with the retired instruction on the debug trace
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_top
    import cpu_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      inst_valid,
    input  word_t     inst,
    output logic      debug_wb_valid,
    output word_t     debug_wb_inst,
    output logic      debug_wb_rf_wen,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     rs_value;
    word_t     rt_value;
    word_t     exe_result;

    decode_bus_if dec_bus ();  // Decode outputs
    decode_bus_if exe_bus ();  // Copy held in execute
    wb_bus_if     wb_bus ();

    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .dec        (dec_bus.producer)
    );

    bypass_unit u_bypass (
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .exe        (exe_bus.consumer),
        .exe_result (exe_result),
        .wb         (wb_bus.sink),
        .rs_value   (rs_value),
        .rt_value   (rt_value)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .reset      (reset),
        .wb         (wb_bus.sink),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data)
    );

    execute_stage u_execute (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec_bus.consumer),
        .exe_bus    (exe_bus.producer),
        .exe_result (exe_result),
        .wb         (wb_bus.producer)
    );

    assign debug_wb_valid    = wb_bus.valid;
    assign debug_wb_inst     = wb_bus.inst;
    assign debug_wb_rf_wen   = wb_bus.wen;
    assign debug_wb_rf_wnum  = wb_bus.waddr;
    assign debug_wb_rf_wdata = wb_bus.wdata;

endmodule

// ==== test/cpu_tb.sv ====
//////////////////////////////////////////////////
// Integer pipeline testbench
// Strobes instructions into the three-stage core,
// predicts every retirement with a register model
// and checks the debug trace with assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_tb
    import cpu_isa_pkg::*;
();

    localparam int MAX_CYCLES = 600;  // About 460 cycles of stimulus and drain

    typedef struct packed {
        word_t     inst;
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
    } trace_t;

    logic      clk;
    logic      reset;
    logic      inst_valid;
    word_t     inst;
    logic      debug_wb_valid;
    word_t     debug_wb_inst;
    logic      debug_wb_rf_wen;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    integer     seed;
    int         cycle_count = 0;
    int         issued;
    int         retired;
    word_t      model_rf [0:31];    // Architectural state in program order
    trace_t     expect_q [$];
    trace_t     head;               // Oldest outstanding retirement
    logic       head_ok;
    logic [2:0] strobe_hist;
    funct_t     r_functs [0:10] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                                    FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    opcode_t    i_opcodes [0:6] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                    OP_XORI, OP_LUI};

    cpu_top dut (
        .clk               (clk),
        .reset             (reset),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_inst     (debug_wb_inst),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Trace check failed");
    endtask

    task automatic report_value(input string name, input word_t exp, input word_t act);
        report_failure($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
    endtask

    task automatic refresh_head();
        head_ok = (expect_q.size() > 0);
        if (head_ok) begin
            head = expect_q[0];
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles, pipeline never drained",
                                     MAX_CYCLES));
        end
    end

    // Strobe history and retirement bookkeeping
    always @(posedge clk) begin
        if (reset) begin
            strobe_hist <= 3'b000;
        end else begin
            strobe_hist <= {strobe_hist[1:0], inst_valid};
            if (debug_wb_valid) begin
                retired = retired + 1;
                if (expect_q.size() > 0) begin
                    void'(expect_q.pop_front());
                end
                refresh_head();
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) reset |=> !debug_wb_valid)
        else report_failure("Trace valid set right after a reset cycle");

    // One trace cycle exactly three cycles after each strobe, none for gaps
    a_trace_timing: assert property (@(posedge clk) disable iff (reset)
        debug_wb_valid == strobe_hist[2])
        else report_value("debug_wb_valid", word_t'($sampled(strobe_hist[2])),
                          word_t'($sampled(debug_wb_valid)));

    a_trace_pending: assert property (@(posedge clk) disable iff (reset)
        debug_wb_valid |-> head_ok)
        else report_failure("Instruction retired while none was outstanding");

    a_trace_inst: assert property (@(posedge clk) disable iff (reset)
        debug_wb_valid |-> (debug_wb_inst == head.inst))
        else report_value("debug_wb_inst", $sampled(head.inst), $sampled(debug_wb_inst));

    a_trace_wen: assert property (@(posedge clk) disable iff (reset)
        debug_wb_valid |-> (debug_wb_rf_wen == head.wen))
        else report_value("debug_wb_rf_wen", word_t'($sampled(head.wen)),
                          word_t'($sampled(debug_wb_rf_wen)));

    a_trace_wnum: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_valid && head.wen) |-> (debug_wb_rf_wnum == head.wnum))
        else report_value("debug_wb_rf_wnum", word_t'($sampled(head.wnum)),
                          word_t'($sampled(debug_wb_rf_wnum)));

    a_trace_wdata: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_valid && head.wen) |-> (debug_wb_rf_wdata == head.wdata))
        else report_value("debug_wb_rf_wdata", $sampled(head.wdata),
                          $sampled(debug_wb_rf_wdata));

    function automatic word_t encode_r(funct_t fn, reg_addr_t rd, reg_addr_t rs,
                                       reg_addr_t rt, logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t encode_i(opcode_t op, reg_addr_t rt, reg_addr_t rs,
                                       logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] v;
        v = $random(seed);
        return int'(v % n);
    endfunction

    function automatic reg_addr_t rand_reg(input logic nonzero);
        reg_addr_t r;
        r = reg_addr_t'($random(seed));
        if (nonzero && r == REG_ZERO) begin
            r = 5'd1;
        end
        return r;
    endfunction

    function automatic word_t random_inst();
        int kind;
        kind = rand_below(20);
        if (kind < 11) begin
            return encode_r(r_functs[kind], rand_reg(0), rand_reg(0), rand_reg(0),
                            5'($random(seed)));
        end else if (kind < 18) begin
            return encode_i(i_opcodes[kind - 11], rand_reg(0), rand_reg(0),
                            16'($random(seed)));
        end
        return $random(seed);  // Mostly unknown encodings
    endfunction

    // Expected write of one instruction against the model state
    function automatic void predict_write(input word_t iw, output logic wen,
                                          output reg_addr_t wnum, output word_t wdata);
        opcode_t    op;
        funct_t     fn;
        word_t      rs_v;
        word_t      rt_v;
        word_t      simm;
        word_t      zimm;
        logic [4:0] sh;
        logic       known;
        op    = iw[31:26];
        fn    = iw[5:0];
        rs_v  = model_rf[iw[25:21]];
        rt_v  = model_rf[iw[20:16]];
        sh    = iw[10:6];
        simm  = {{16{iw[15]}}, iw[15:0]};
        zimm  = {16'h0000, iw[15:0]};
        known = 1'b1;
        wdata = '0;
        wnum  = (op == OP_SPECIAL) ? iw[15:11] : iw[20:16];
        if (op == OP_SPECIAL) begin
            case (fn)
                FN_ADDU: wdata = rs_v + rt_v;
                FN_SUBU: wdata = rs_v - rt_v;
                FN_AND:  wdata = rs_v & rt_v;
                FN_OR:   wdata = rs_v | rt_v;
                FN_XOR:  wdata = rs_v ^ rt_v;
                FN_NOR:  wdata = ~(rs_v | rt_v);
                FN_SLT:  wdata = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
                FN_SLTU: wdata = (rs_v < rt_v) ? 32'd1 : 32'd0;
                FN_SLL:  wdata = rt_v << sh;
                FN_SRL:  wdata = rt_v >> sh;
                FN_SRA:  wdata = $signed(rt_v) >>> sh;
                default: known = 1'b0;
            endcase
        end else begin
            case (op)
                OP_ADDIU: wdata = rs_v + simm;
                OP_SLTI:  wdata = ($signed(rs_v) < $signed(simm)) ? 32'd1 : 32'd0;
                OP_SLTIU: wdata = (rs_v < simm) ? 32'd1 : 32'd0;
                OP_ANDI:  wdata = rs_v & zimm;
                OP_ORI:   wdata = rs_v | zimm;
                OP_XORI:  wdata = rs_v ^ zimm;
                OP_LUI:   wdata = {iw[15:0], 16'h0000};
                default:  known = 1'b0;
            endcase
        end
        wen = known && (wnum != REG_ZERO);
    endfunction

    task automatic issue(input word_t iw);
        trace_t    entry;
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
        @(posedge clk);
        #1;
        inst_valid = 1'b1;
        inst       = iw;
        predict_write(iw, wen, wnum, wdata);
        if (wen) begin
            model_rf[wnum] = wdata;
        end
        entry = '{inst: iw, wen: wen, wnum: wnum, wdata: wdata};
        expect_q.push_back(entry);
        issued++;
        refresh_head();
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            inst       = $random(seed);  // Bus content must be ignored
        end
    endtask

    task automatic run_forwarding_chain(input int count);
        reg_addr_t hist [0:2];  // Destinations 1, 2 and 3 places ahead
        reg_addr_t rd;
        hist = '{5'd1, 5'd2, 5'd3};
        repeat (count) begin
            do begin
                rd = rand_reg(1);
            end while (rd == hist[0] || rd == hist[1] || rd == hist[2]);
            issue(encode_r(r_functs[rand_below(11)], rd, hist[rand_below(3)],
                           hist[rand_below(3)], 5'($random(seed))));
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = rd;
        end
    endtask

    initial begin
        seed       = 75;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        issued     = 0;
        retired    = 0;
        head       = '0;
        head_ok    = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_rf[r] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        idle(6);  // No strobe, no trace
        for (int r = 0; r < 32; r++) begin
            issue(encode_i(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), 16'h0000));
        end

        for (int r = 1; r < 32; r++) begin
            issue(encode_i(OP_LUI, reg_addr_t'(r), REG_ZERO, 16'($random(seed))));
            issue(encode_i(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), 16'($random(seed))));
        end

        for (int f = 0; f < 11; f++) begin
            repeat (2) begin
                issue(encode_r(r_functs[f], rand_reg(1), rand_reg(0), rand_reg(0),
                               5'($random(seed))));
                idle(2);
            end
        end

        // Immediate extension and compare boundaries
        issue(encode_i(OP_LUI, 5'd1, REG_ZERO, 16'h8000));     // Most negative word
        issue(encode_i(OP_LUI, 5'd2, REG_ZERO, 16'h7fff));
        issue(encode_i(OP_ORI, 5'd2, 5'd2, 16'hffff));         // Most positive word
        issue(encode_i(OP_ADDIU, 5'd3, 5'd2, 16'h0001));       // Wraps around
        issue(encode_i(OP_ADDIU, 5'd4, REG_ZERO, 16'h8000));
        issue(encode_i(OP_ADDIU, 5'd5, REG_ZERO, 16'hffff));   // Minus one
        issue(encode_i(OP_SLTI, 5'd6, 5'd1, 16'h8000));
        issue(encode_i(OP_SLTI, 5'd7, 5'd2, 16'h7fff));
        issue(encode_i(OP_SLTI, 5'd8, 5'd5, 16'hffff));        // Equal operands
        issue(encode_i(OP_SLTIU, 5'd9, 5'd1, 16'hffff));
        issue(encode_i(OP_SLTIU, 5'd10, 5'd5, 16'hffff));
        issue(encode_i(OP_SLTIU, 5'd11, REG_ZERO, 16'h0001));
        issue(encode_i(OP_ANDI, 5'd12, 5'd5, 16'h8001));
        issue(encode_i(OP_ORI, 5'd13, REG_ZERO, 16'h8000));
        issue(encode_i(OP_XORI, 5'd14, 5'd5, 16'hf0f0));
        issue(encode_i(OP_LUI, 5'd15, 5'd5, 16'hfedc));
        idle(3);

        // Same register in execute and writeback, newest must win
        issue(encode_i(OP_ADDIU, 5'd20, REG_ZERO, 16'h0001));
        issue(encode_i(OP_ADDIU, 5'd20, REG_ZERO, 16'h0002));
        issue(encode_r(FN_ADDU, 5'd21, 5'd20, 5'd20, 5'd0));
        run_forwarding_chain(60);
        idle(3);

        issue(encode_r(FN_ADDU, REG_ZERO, 5'd1, 5'd2, 5'd0));
        issue(encode_i(OP_ORI, REG_ZERO, 5'd1, 16'hffff));
        issue(encode_i(OP_LUI, REG_ZERO, REG_ZERO, 16'h1234));
        issue(encode_r(6'h3e, 5'd7, 5'd1, 5'd2, 5'd0));       // Unknown funct
        issue(encode_i(OP_ORI, 5'd19, 5'd7, 16'h0000));        // r7 keeps old value
        issue({6'h3f, 26'h1234567});                           // Unknown opcode
        issue(encode_i(OP_ORI, 5'd16, REG_ZERO, 16'h0000));
        issue(encode_r(FN_OR, 5'd17, REG_ZERO, REG_ZERO, 5'd0));
        idle(3);
        issue(encode_i(OP_ORI, 5'd18, REG_ZERO, 16'h0000));

        for (int n = 0; n < 60; n++) begin
            issue(random_inst());
            idle(rand_below(3));
        end

        idle(6);
        if (retired != issued || expect_q.size() != 0) begin
            report_failure($sformatf("Issued %0d instructions but %0d retired",
                                     issued, retired));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
verilog/cpu_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/cpu_buses.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/bypass_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/cpu_top.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_pipeline

sources:
  - verilog/cpu_isa_pkg.sv
  - verilog/cpu_ctrl_pkg.sv
  - verilog/cpu_buses.sv
  - verilog/alu.sv
  - verilog/reg_file.sv
  - verilog/bypass_unit.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/cpu_top.sv
  - target: test
    files:
      - test/cpu_tb.sv
